/* Bender.yml */
package:
  name: act_gbf

sources:
  - files:
      - act_gbf_pkg.sv
      - gbf_ram.sv
      - word_unpacker.sv
      - gbf_read_channel.sv
      - act_gbf_top.sv
  - target: test
    files:
      - act_gbf_checker.sv
      - tb_act_gbf.sv

/* act_gbf_checker.sv */
//====================
// keeps the expected items of each channel in write order
// a pop is compared on the rising edge where en and rdy are both high
//====================
`timescale 1ns/1ps

module act_gbf_checker (
    input  logic                          clk,
    input  logic                          rst_n,
    input  act_gbf_pkg::gbf_wr_t          act_wr,
    input  act_gbf_pkg::gbf_wr_t          flg_wr,
    input  logic                          act_rdy,
    input  logic                          act_en,
    input  logic [act_gbf_pkg::act_w-1:0] act_dat,
    input  logic                          flg_rdy,
    input  logic                          flg_en,
    input  logic [act_gbf_pkg::flg_w-1:0] flg_dat,
    input  logic                          check_end,
    output int                            mismatch_cnt,
    output int                            other_cnt
);
    import act_gbf_pkg::*;

    logic [act_w-1:0] act_q [$];
    logic [flg_w-1:0] flg_q [$];

    // item shown last cycle and not popped
    logic             act_hold;
    logic             flg_hold;
    logic [act_w-1:0] act_last;
    logic [flg_w-1:0] flg_last;
    logic             end_done;

    initial begin
        mismatch_cnt = 0;
        other_cnt    = 0;
        act_hold     = 1'b0;
        flg_hold     = 1'b0;
        end_done     = 1'b0;
    end

    task automatic compare_item(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0d ns: %s item got %h, expected %h",
                     $time, name, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic report(input string msg);
        $display("%0d ns: %s", $time, msg);
        other_cnt++;
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            //====================
            // stall and presence checks
            //====================
            if (act_hold && (!act_rdy || act_dat !== act_last)) begin
                report("act channel lost or changed its item while stalled");
            end
            if (flg_hold && (!flg_rdy || flg_dat !== flg_last)) begin
                report("flg channel lost or changed its item while stalled");
            end
            if (act_rdy && act_q.size() == 0) begin
                report("act channel shows an item that was never written");
            end
            if (flg_rdy && flg_q.size() == 0) begin
                report("flg channel shows an item that was never written");
            end

            // pops against the reference queues
            if (act_en && act_rdy && act_q.size() != 0) begin
                compare_item("act", act_dat, act_q.pop_front());
            end
            if (flg_en && flg_rdy && flg_q.size() != 0) begin
                compare_item("flg", flg_dat, flg_q.pop_front());
            end

            // new words are sliced most significant item first
            if (act_wr.en) begin
                for (int k = 0; k < port_w / act_w; k++) begin
                    act_q.push_back(act_wr.dat[port_w-1-k*act_w -: act_w]);
                end
            end
            if (flg_wr.en) begin
                for (int k = 0; k < port_w / flg_w; k++) begin
                    flg_q.push_back(flg_wr.dat[port_w-1-k*flg_w -: flg_w]);
                end
            end

            act_hold = act_rdy && !act_en;
            flg_hold = flg_rdy && !flg_en;
            act_last = act_dat;
            flg_last = flg_dat;

            // leftovers once the stimulus is done
            if (check_end && !end_done) begin
                end_done = 1'b1;
                if (act_q.size() != 0) begin
                    report($sformatf("act channel: %0d written items never came out",
                                     act_q.size()));
                end
                if (flg_q.size() != 0) begin
                    report($sformatf("flg channel: %0d written items never came out",
                                     flg_q.size()));
                end
            end
        end
    end

endmodule

/* act_gbf_pkg.sv */
//====================
// widths and port types shared by both activation buffers
// each buffer holds 32 port words, the writer must not overrun it
//====================
package act_gbf_pkg;

    //====================
    // widths
    //====================

    // one word on the write port of a buffer
    localparam int port_w = 64;

    // one activation byte
    localparam int act_w = 8;

    // sparsity mask of one block, one bit per channel of a 16-deep block
    localparam int flg_w = 16;

    // 32 words per buffer
    localparam int gbf_addr_w = 5;

    // one bit wider than the address so a full buffer still counts
    localparam int gbf_cnt_w = 6;

    //====================
    // types
    //====================

    typedef logic [port_w-1:0] port_word_t;

    typedef logic [gbf_addr_w-1:0] gbf_addr_t;

    // external write port of one buffer
    // addr is chosen by the writer, in order from 0 with wrap
    typedef struct packed {
        logic       en;
        gbf_addr_t  addr;
        port_word_t dat;
    } gbf_wr_t;

endpackage

/* act_gbf_top.sv */
//====================
// activation data and activation flag buffers, fully independent
// pulse act_en or flg_en only while the matching rdy is high
//====================
`timescale 1ns/1ps

module act_gbf_top (
    input  logic                          clk,
    input  logic                          rst_n,

    // write ports, one per buffer
    input  act_gbf_pkg::gbf_wr_t          act_wr,
    input  act_gbf_pkg::gbf_wr_t          flg_wr,

    // activation items
    output logic                          act_rdy,
    input  logic                          act_en,
    output logic [act_gbf_pkg::act_w-1:0] act_dat,

    // flag blocks
    output logic                          flg_rdy,
    input  logic                          flg_en,
    output logic [act_gbf_pkg::flg_w-1:0] flg_dat
);
    import act_gbf_pkg::*;

    //====================
    // activation data
    //====================

    // eight bytes per port word
    gbf_read_channel #(
        .item_w (act_w)
    ) u_act (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (act_wr),
        .rdy   (act_rdy),
        .en    (act_en),
        .dat   (act_dat)
    );

    //====================
    // activation flags
    //====================

    // four sparsity masks per port word
    gbf_read_channel #(
        .item_w (flg_w)
    ) u_flg (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (flg_wr),
        .rdy   (flg_rdy),
        .en    (flg_en),
        .dat   (flg_dat)
    );

endmodule

/* all.f */
act_gbf_pkg.sv
gbf_ram.sv
word_unpacker.sv
gbf_read_channel.sv
act_gbf_top.sv
act_gbf_checker.sv
tb_act_gbf.sv

/* gbf_ram.sv */
//====================
// simple dual-port SRAM, one write and one read per cycle
// read data shows one cycle after rd_en and holds until the next read
//====================
`timescale 1ns/1ps

module gbf_ram (
    input  logic                    clk,
    input  logic                    rst_n,
    input  act_gbf_pkg::gbf_wr_t    wr,
    input  logic                    rd_en,
    input  act_gbf_pkg::gbf_addr_t  rd_addr,
    output act_gbf_pkg::port_word_t rd_dat
);
    import act_gbf_pkg::*;

    port_word_t mem [2**gbf_addr_w];

    // write port
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.dat;
        end
    end

    // registered read port
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_dat <= '0;
        end else if (rd_en) begin
            rd_dat <= mem[rd_addr];
        end
    end

endmodule

/* gbf_read_channel.sv */
//====================
// one global buffer channel, stored words are read in address order from 0
// no write ready, a write stalls any read issue in the same cycle
//====================
`timescale 1ns/1ps

module gbf_read_channel #(
    parameter int item_w = act_gbf_pkg::act_w
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  act_gbf_pkg::gbf_wr_t wr,
    output logic                 rdy,
    input  logic                 en,
    output logic [item_w-1:0]    dat
);
    import act_gbf_pkg::*;

    logic [gbf_cnt_w-1:0] used_q;
    gbf_addr_t            rd_addr_q;
    logic                 buf_val;
    logic                 unp_wr_rdy;
    logic                 all_rdy;
    logic                 all_rdy_q;
    logic                 rd_issue;
    logic                 rd_issue_q;
    port_word_t           ram_dat;

    //====================
    // read issue
    //====================

    // write and read of the SRAM exclude each other
    assign buf_val = (used_q != '0) && !wr.en;
    assign all_rdy = unp_wr_rdy && buf_val;

    // rising edge only, one read per empty unpacker
    assign rd_issue = all_rdy && !all_rdy_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            all_rdy_q  <= 1'b0;
            rd_issue_q <= 1'b0;
        end else begin
            all_rdy_q  <= all_rdy;
            rd_issue_q <= rd_issue;
        end
    end

    //====================
    // occupancy and read address
    //====================

    // rd_issue never fires with wr.en, so the two branches cannot collide
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            used_q <= '0;
        end else if (wr.en) begin
            used_q <= used_q + gbf_cnt_w'(1);
        end else if (rd_issue) begin
            used_q <= used_q - gbf_cnt_w'(1);
        end
    end

    // wraps with the writer's addresses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr_q <= '0;
        end else if (rd_issue) begin
            rd_addr_q <= rd_addr_q + gbf_addr_w'(1);
        end
    end

    //====================
    // storage and unpacker
    //====================

    gbf_ram u_ram (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (wr),
        .rd_en   (rd_issue),
        .rd_addr (rd_addr_q),
        .rd_dat  (ram_dat)
    );

    // word is on ram_dat the cycle after the issue
    word_unpacker #(
        .item_w (item_w)
    ) u_unpacker (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_rdy (unp_wr_rdy),
        .wr_en  (rd_issue_q),
        .wr_dat (ram_dat),
        .rd_rdy (rdy),
        .rd_en  (en),
        .rd_dat (dat)
    );

endmodule

/* tb_act_gbf.sv */
//====================
// drives act_gbf_top from a step table
// a pop step waits for rdy before it is applied
//====================
`timescale 1ns/1ps

module tb_act_gbf;
    import act_gbf_pkg::*;

    // one row of the stimulus table
    // flg selects the channel
    typedef struct packed {
        logic       flg;
        logic       wr;
        port_word_t word;
        logic       pop;
        logic [7:0] idle;
    } step_t;

    logic             clk;
    logic             rst_n;
    gbf_wr_t          act_wr;
    gbf_wr_t          flg_wr;
    logic             act_rdy;
    logic             act_en;
    logic [act_w-1:0] act_dat;
    logic             flg_rdy;
    logic             flg_en;
    logic [flg_w-1:0] flg_dat;
    logic             check_end;
    int               mismatch_cnt;
    int               other_cnt;

    step_t       steps [$];
    int          pending [2];
    gbf_addr_t   act_wa;
    gbf_addr_t   flg_wa;
    logic [31:0] rng;
    int          cycles;
    int          limit;

    always #50 clk = ~clk;

    act_gbf_top u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .act_wr  (act_wr),
        .flg_wr  (flg_wr),
        .act_rdy (act_rdy),
        .act_en  (act_en),
        .act_dat (act_dat),
        .flg_rdy (flg_rdy),
        .flg_en  (flg_en),
        .flg_dat (flg_dat)
    );

    act_gbf_checker u_chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .act_wr       (act_wr),
        .flg_wr       (flg_wr),
        .act_rdy      (act_rdy),
        .act_en       (act_en),
        .act_dat      (act_dat),
        .flg_rdy      (flg_rdy),
        .flg_en       (flg_en),
        .flg_dat      (flg_dat),
        .check_end    (check_end),
        .mismatch_cnt (mismatch_cnt),
        .other_cnt    (other_cnt)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic port_word_t next_word();
        port_word_t w;
        rng = xorshift(rng);
        w[63:32] = rng;
        rng = xorshift(rng);
        w[31:0] = rng;
        return w;
    endfunction

    // a pop is only kept while items are still owed on that channel
    function automatic void add_step(input logic flg, input logic wr, input port_word_t word,
                                     input logic pop, input int idle);
        step_t s;
        s.flg  = flg;
        s.wr   = wr;
        s.word = word;
        s.pop  = pop && (pending[flg] > 0);
        s.idle = 8'(idle);
        if (s.pop) begin
            pending[flg]--;
        end
        if (wr) begin
            pending[flg] += flg ? port_w / flg_w : port_w / act_w;
        end
        steps.push_back(s);
    endfunction

    function automatic void drain(input logic flg);
        while (pending[flg] > 0) begin
            add_step(flg, 1'b0, '0, 1'b1, 0);
        end
    endfunction

    function automatic void build_table();
        //====================
        // idle, single words, back-pressure
        //====================
        add_step(1'b0, 1'b0, '0, 1'b0, 20);
        add_step(1'b0, 1'b1, 64'h8877_6655_4433_2211, 1'b0, 0);
        drain(1'b0);
        add_step(1'b1, 1'b1, 64'hf00d_a5a5_0ff0_1234, 1'b0, 0);
        add_step(1'b0, 1'b1, 64'h0123_4567_89ab_cdef, 1'b0, 0);
        for (int i = 0; i < 4; i++) begin
            add_step(1'b1, 1'b0, '0, 1'b1, 0);
            add_step(1'b0, 1'b0, '0, 1'b1, 1);
        end
        drain(1'b0);
        add_step(1'b0, 1'b1, 64'hc001_d00d_cafe_beef, 1'b0, 0);
        add_step(1'b0, 1'b0, '0, 1'b1, 0);
        add_step(1'b0, 1'b0, '0, 1'b1, 30);
        add_step(1'b1, 1'b1, 64'h5555_aaaa_3333_cccc, 1'b0, 0);
        add_step(1'b1, 1'b0, '0, 1'b1, 25);
        drain(1'b0);
        drain(1'b1);
        //====================
        // writes during pops, then full buffers
        //====================
        add_step(1'b0, 1'b1, next_word(), 1'b0, 0);
        add_step(1'b1, 1'b1, next_word(), 1'b0, 0);
        for (int i = 0; i < 16; i++) begin
            add_step(1'b0, i % 3 == 0, next_word(), 1'b1, 0);
            add_step(1'b1, i % 5 == 0, next_word(), 1'b1, 0);
        end
        drain(1'b0);
        drain(1'b1);
        for (int i = 0; i < 32; i++) begin
            add_step(1'b0, 1'b1, next_word(), 1'b0, 0);
        end
        for (int i = 0; i < 32; i++) begin
            add_step(1'b1, 1'b1, next_word(), 1'b0, 0);
        end
        drain(1'b0);
        drain(1'b1);
    endfunction

    // entered and left on a falling edge
    task automatic apply_step(input step_t s);
        if (s.pop) begin
            while (!(s.flg ? flg_rdy : act_rdy)) begin
                @(negedge clk);
            end
        end
        if (s.flg) begin
            flg_wr.en   = s.wr;
            flg_wr.addr = flg_wa;
            flg_wr.dat  = s.word;
            flg_en      = s.pop;
            if (s.wr) begin
                flg_wa = flg_wa + 1'b1;
            end
        end else begin
            act_wr.en   = s.wr;
            act_wr.addr = act_wa;
            act_wr.dat  = s.word;
            act_en      = s.pop;
            if (s.wr) begin
                act_wa = act_wa + 1'b1;
            end
        end
        @(negedge clk);
        act_wr.en = 1'b0;
        flg_wr.en = 1'b0;
        act_en    = 1'b0;
        flg_en    = 1'b0;
        repeat (s.idle) @(negedge clk);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        act_wr     = '0;
        flg_wr     = '0;
        act_en     = 1'b0;
        flg_en     = 1'b0;
        check_end  = 1'b0;
        act_wa     = '0;
        flg_wa     = '0;
        rng        = 32'h3497_45b5;
        cycles     = 0;
        pending[0] = 0;
        pending[1] = 0;
        build_table();
        limit = 16 * steps.size() + 200;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        repeat (4) @(negedge clk);
        check_end = 1'b1;
        repeat (2) @(negedge clk);
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* word_unpacker.sv */
//====================
// splits one port word into items, most significant item first
// item_w must divide port_w
//====================
`timescale 1ns/1ps

module word_unpacker #(
    parameter int item_w = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic                    wr_rdy,
    input  logic                    wr_en,
    input  act_gbf_pkg::port_word_t wr_dat,
    output logic                    rd_rdy,
    input  logic                    rd_en,
    output logic [item_w-1:0]       rd_dat
);
    import act_gbf_pkg::*;

    localparam int n_items = port_w / item_w;
    localparam int left_w  = $clog2(n_items + 1);

    port_word_t        word_q;
    logic [left_w-1:0] left_q;
    logic              load;
    logic              pop;

    // a load only lands on an empty unpacker, a pop only on a full one
    assign load = wr_en && wr_rdy;
    assign pop  = rd_en && rd_rdy;

    //====================
    // item count
    //====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            left_q <= '0;
        end else if (load) begin
            left_q <= left_w'(n_items);
        end else if (pop) begin
            left_q <= left_q - left_w'(1);
        end
    end

    //====================
    // word shifter
    //====================

    // next item always sits at the top of the word
    always_ff @(posedge clk) begin
        if (load) begin
            word_q <= wr_dat;
        end else if (pop) begin
            word_q <= word_q << item_w;
        end
    end

    assign wr_rdy = (left_q == '0);
    assign rd_rdy = (left_q != '0);
    assign rd_dat = word_q[port_w-1 -: item_w];

endmodule
